/* design/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;
	typedef logic [3:0]  wmask_t;
	typedef logic [11:0] csr_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_SRL,
		ALU_SRA,
		ALU_SLL,
		ALU_LESS,
		ALU_ULESS
	} alu_op_e;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXECUTE,
		ST_LOAD_WB,
		ST_HALT
	} core_state_e;

	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MCYCLE   = 12'hB00;

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/decode_if.sv */
`default_nettype none

interface decode_if;
	import rv_core_pkg::*;

	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	word_t     imm;
	csr_addr_t csr_addr;

	modport dec (output opcode, funct3, funct7, rs1, rs2, rd, imm, csr_addr);
	modport rf  (input rs1, rs2, rd);
	modport exu (input opcode, funct3, funct7, imm);

endinterface

`default_nettype wire

/* design/core_fsm.sv */
`default_nettype none

module core_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  rv_core_pkg::opcode_t opcode,
	input  rv_core_pkg::funct3_t funct3,
	output logic                ir_load,
	output logic                pc_step,
	output logic                rf_we,
	output logic                rf_sel_load,
	output logic                csr_we,
	output logic                dmem_re,
	output logic                dmem_we,
	output logic                halted
);
	import rv_core_pkg::*;

	core_state_e state;
	core_state_e state_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_FETCH;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt   = state;
		ir_load     = 1'b0;
		pc_step     = 1'b0;
		rf_we       = 1'b0;
		rf_sel_load = 1'b0;
		csr_we      = 1'b0;
		dmem_re     = 1'b0;
		dmem_we     = 1'b0;
		halted      = 1'b0;
		case (state)
			ST_FETCH: begin
				ir_load   = 1'b1;
				state_nxt = ST_EXECUTE;
			end
			ST_EXECUTE: begin
				state_nxt = ST_FETCH;
				case (opcode)
					OPC_LOAD: begin
						dmem_re   = 1'b1;
						state_nxt = ST_LOAD_WB;
					end
					OPC_STORE: begin
						dmem_we = 1'b1;
						pc_step = 1'b1;
					end
					OPC_SYSTEM: begin
						if (funct3 == 3'b000) begin
							state_nxt = ST_HALT; // ebreak
						end else begin
							csr_we  = 1'b1;
							rf_we   = 1'b1;
							pc_step = 1'b1;
						end
					end
					OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP, OPC_OP_IMM: begin
						rf_we   = 1'b1;
						pc_step = 1'b1;
					end
					default: pc_step = 1'b1; // branch, or skip unknown
				endcase
			end
			ST_LOAD_WB: begin
				rf_we       = 1'b1;
				rf_sel_load = 1'b1;
				pc_step     = 1'b1;
				state_nxt   = ST_FETCH;
			end
			default: halted = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* design/pc_counter.sv */
`default_nettype none

module pc_counter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               pc_step,
	input  rv_core_pkg::word_t jump,
	output rv_core_pkg::word_t pc
);
	import rv_core_pkg::*;

	word_t pc_nxt;

	// zero target means fall through
	assign pc_nxt = (jump != '0) ? jump : pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (pc_step)
			pc <= pc_nxt;
	end

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`default_nettype none

module decode_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ir_load,
	input  rv_core_pkg::word_t imem_rdata,
	decode_if.dec              dec
);
	import rv_core_pkg::*;

	word_t ir;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ir <= '0;
		else if (ir_load)
			ir <= imem_rdata;
	end

	assign dec.opcode   = ir[6:0];
	assign dec.rd       = ir[11:7];
	assign dec.funct3   = ir[14:12];
	assign dec.rs1      = ir[19:15];
	assign dec.rs2      = ir[24:20];
	assign dec.funct7   = ir[31:25];
	assign dec.csr_addr = ir[31:20];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'd0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	always_comb begin
		case (ir[6:0])
			OPC_STORE:            dec.imm = imm_s;
			OPC_BRANCH:           dec.imm = imm_b;
			OPC_LUI, OPC_AUIPC:   dec.imm = imm_u;
			OPC_JAL:              dec.imm = imm_j;
			default:              dec.imm = imm_i; // op-imm, load, jalr, system
		endcase
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	decode_if.rf               rf,
	input  logic               we,
	input  rv_core_pkg::word_t wdata,
	output rv_core_pkg::word_t src1,
	output rv_core_pkg::word_t src2
);
	import rv_core_pkg::*;

	word_t regs [1:31]; // no storage for x0

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rf.rd != '0) begin
			regs[rf.rd] <= wdata;
		end
	end

	assign src1 = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
	assign src2 = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`default_nettype none

module exec_unit (
	decode_if.exu               exu,
	input  rv_core_pkg::word_t  src1,
	input  rv_core_pkg::word_t  src2,
	input  rv_core_pkg::word_t  pc,
	input  rv_core_pkg::word_t  csr_val,
	output rv_core_pkg::word_t  val,
	output rv_core_pkg::word_t  jump,
	output rv_core_pkg::word_t  csr_wdata,
	output rv_core_pkg::word_t  addr,
	output rv_core_pkg::wmask_t wmask
);
	import rv_core_pkg::*;

	word_t       lop;
	word_t       rop;
	alu_op_e     f3_op;
	alu_op_e     alu_op;
	logic        do_sub;
	logic [32:0] alu_sum;
	logic        alu_less;
	logic        alu_uless;
	word_t       alu_val;
	logic [32:0] br_diff;
	logic        br_eq;
	logic        br_less;
	logic        br_uless;
	logic        br_take;
	logic        jump_en;
	word_t       jump_base;
	word_t       store_data;
	wmask_t      base_mask;

	always_comb begin
		case (exu.opcode)
			OPC_LUI:           begin lop = exu.imm; rop = '0;      end
			OPC_AUIPC:         begin lop = pc;      rop = exu.imm; end
			OPC_JAL, OPC_JALR: begin lop = pc;      rop = 32'd4;   end // link value
			OPC_OP_IMM:        begin lop = src1;    rop = exu.imm; end
			OPC_OP:            begin lop = src1;    rop = src2;    end
			default:           begin lop = '0;      rop = '0;      end
		endcase
	end

	always_comb begin
		case (exu.funct3)
			3'b000:  f3_op = (exu.opcode == OPC_OP && exu.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  f3_op = ALU_SLL;
			3'b010:  f3_op = ALU_LESS;
			3'b011:  f3_op = ALU_ULESS;
			3'b100:  f3_op = ALU_XOR;
			3'b101:  f3_op = exu.funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  f3_op = ALU_OR;
			default: f3_op = ALU_AND;
		endcase
	end

	assign alu_op = (exu.opcode == OPC_OP || exu.opcode == OPC_OP_IMM) ? f3_op : ALU_ADD;

	// one adder for add, sub and both compares
	assign do_sub    = alu_op inside {ALU_SUB, ALU_LESS, ALU_ULESS};
	assign alu_sum   = {1'b0, lop} + {1'b0, do_sub ? ~rop : rop} + {32'd0, do_sub};
	assign alu_uless = ~alu_sum[32]; // no carry means borrow
	assign alu_less  = (lop[31] & ~rop[31]) | (~(lop[31] ^ rop[31]) & alu_sum[31]);

	always_comb begin
		case (alu_op)
			ALU_AND:   alu_val = lop & rop;
			ALU_XOR:   alu_val = lop ^ rop;
			ALU_OR:    alu_val = lop | rop;
			ALU_SRL:   alu_val = lop >> rop[4:0];
			ALU_SRA:   alu_val = $signed(lop) >>> rop[4:0];
			ALU_SLL:   alu_val = lop << rop[4:0];
			ALU_LESS:  alu_val = {31'd0, alu_less};
			ALU_ULESS: alu_val = {31'd0, alu_uless};
			default:   alu_val = alu_sum[31:0];
		endcase
	end

	// branch compare
	assign br_diff  = {1'b0, src1} + {1'b0, ~src2} + 33'd1;
	assign br_eq    = (br_diff[31:0] == '0);
	assign br_uless = ~br_diff[32];
	assign br_less  = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & br_diff[31]);

	always_comb begin
		case (exu.funct3)
			3'b000:  br_take = br_eq;
			3'b001:  br_take = ~br_eq;
			3'b100:  br_take = br_less;
			3'b101:  br_take = ~br_less;
			3'b110:  br_take = br_uless;
			3'b111:  br_take = ~br_uless;
			default: br_take = 1'b0;
		endcase
	end

	assign jump_en   = (exu.opcode == OPC_JAL) || (exu.opcode == OPC_JALR) ||
	                   (exu.opcode == OPC_BRANCH && br_take);
	assign jump_base = (exu.opcode == OPC_JALR) ? src1 : pc;
	assign jump      = jump_en ? ((jump_base + exu.imm) & ~32'd1) : '0;

	assign addr = src1 + exu.imm;

	always_comb begin
		case (exu.funct3)
			3'b000:  begin base_mask = 4'h1; store_data = {4{src2[7:0]}};  end // sb
			3'b001:  begin base_mask = 4'h3; store_data = {2{src2[15:0]}}; end // sh
			3'b010:  begin base_mask = 4'hf; store_data = src2;            end // sw
			default: begin base_mask = 4'h0; store_data = src2;            end
		endcase
	end

	assign wmask = (exu.opcode == OPC_STORE) ? wmask_t'(base_mask << addr[1:0]) : '0;
	assign val   = (exu.opcode == OPC_STORE) ? store_data : alu_val;

	always_comb begin
		case (exu.funct3)
			3'b001:  csr_wdata = src1;           // csrrw
			3'b010:  csr_wdata = src1 | csr_val; // csrrs
			default: csr_wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/csr_file.sv */
`default_nettype none

module csr_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rv_core_pkg::csr_addr_t csr_addr,
	input  logic                   we,
	input  rv_core_pkg::word_t     wdata,
	output rv_core_pkg::word_t     csr_val
);
	import rv_core_pkg::*;

	word_t mscratch;
	word_t mcycle;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch <= '0;
			mcycle   <= '0;
		end else begin
			mcycle <= mcycle + 32'd1; // free running
			if (we && csr_addr == CSR_MSCRATCH)
				mscratch <= wdata;
		end
	end

	always_comb begin
		case (csr_addr)
			CSR_MSCRATCH: csr_val = mscratch;
			CSR_MCYCLE:   csr_val = mcycle;
			default:      csr_val = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`default_nettype none

module rv_core_top (
	input  logic                clk,
	input  logic                rst_n,
	output rv_core_pkg::word_t  imem_addr,
	input  rv_core_pkg::word_t  imem_rdata,
	output rv_core_pkg::word_t  dmem_addr,
	output rv_core_pkg::word_t  dmem_wdata,
	output rv_core_pkg::wmask_t dmem_wmask,
	output logic                dmem_we,
	output logic                dmem_re,
	input  rv_core_pkg::word_t  dmem_rdata,
	output logic                halted
);
	import rv_core_pkg::*;

	logic  ir_load;
	logic  pc_step;
	logic  rf_we;
	logic  rf_sel_load;
	logic  csr_we;
	word_t pc;
	word_t jump;
	word_t src1;
	word_t src2;
	word_t exu_val;
	word_t csr_val;
	word_t csr_wdata;
	word_t rf_wdata;

	decode_if d_if ();

	assign imem_addr  = pc;
	assign dmem_wdata = exu_val; // replicated store data on stores

	// writeback select: load data, csr read or alu
	assign rf_wdata = rf_sel_load ? dmem_rdata :
	                  (d_if.opcode == OPC_SYSTEM) ? csr_val : exu_val;

	core_fsm i_core_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.opcode      (d_if.opcode),
		.funct3      (d_if.funct3),
		.ir_load     (ir_load),
		.pc_step     (pc_step),
		.rf_we       (rf_we),
		.rf_sel_load (rf_sel_load),
		.csr_we      (csr_we),
		.dmem_re     (dmem_re),
		.dmem_we     (dmem_we),
		.halted      (halted)
	);

	pc_counter i_pc_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.pc_step (pc_step),
		.jump    (jump),
		.pc      (pc)
	);

	decode_unit i_decode_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir_load    (ir_load),
		.imem_rdata (imem_rdata),
		.dec        (d_if.dec)
	);

	reg_file i_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.rf    (d_if.rf),
		.we    (rf_we),
		.wdata (rf_wdata),
		.src1  (src1),
		.src2  (src2)
	);

	exec_unit i_exec_unit (
		.exu       (d_if.exu),
		.src1      (src1),
		.src2      (src2),
		.pc        (pc),
		.csr_val   (csr_val),
		.val       (exu_val),
		.jump      (jump),
		.csr_wdata (csr_wdata),
		.addr      (dmem_addr),
		.wmask     (dmem_wmask)
	);

	csr_file i_csr_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.csr_addr (d_if.csr_addr),
		.we       (csr_we),
		.wdata    (csr_wdata),
		.csr_val  (csr_val)
	);

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_core_pkg::*;

	localparam word_t EBREAK      = 32'h0010_0073;
	localparam int    INSTR_TOTAL = 145; // words over all six programs
	localparam int    CYCLE_LIMIT = INSTR_TOTAL * 3 + 6 * 18 + 20 + 200;

	logic   clk = 1'b0;
	logic   rst_n;
	word_t  imem_addr;
	word_t  imem_rdata;
	word_t  dmem_addr;
	word_t  dmem_wdata;
	wmask_t dmem_wmask;
	logic   dmem_we;
	logic   dmem_re;
	word_t  dmem_rdata;
	logic   halted;

	word_t       imem [0:255];
	word_t       dmem [0:255];
	word_t       rd_word;
	logic [7:0]  wr_idx;
	word_t       wr_addr_q [$];
	wmask_t      wr_mask_q [$];
	word_t       wr_word_q [$];
	word_t       rd_addr_q [$];
	int          prog_len;
	int          errors;
	int          checks;
	int          cycle_count = 0;

	rv_core_top i_rv_core_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata),
		.halted     (halted)
	);

	always #4 clk = ~clk;

	// memory read data, driven just after the edge
	always @(posedge clk) begin
		#1;
		imem_rdata = imem[imem_addr[9:2]];
		dmem_rdata = rd_word;
	end

	// byte-masked writes and read capture mid-cycle
	always @(negedge clk) begin
		if (dmem_we) begin
			wr_idx = dmem_addr[9:2];
			for (int i = 0; i < 4; i++)
				if (dmem_wmask[i])
					dmem[wr_idx][8*i +: 8] = dmem_wdata[8*i +: 8];
			wr_addr_q.push_back(dmem_addr);
			wr_mask_q.push_back(dmem_wmask);
			wr_word_q.push_back(dmem[wr_idx]);
		end
		if (dmem_re) begin
			rd_word = dmem[dmem_addr[9:2]];
			rd_addr_q.push_back(dmem_addr);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("test failed");
			$finish;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_mask(input string name, input wmask_t got, input wmask_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic word_t fill_word(input int idx);
		return (word_t'(idx) * 32'h0101_0101) ^ 32'hC3A5_0F96;
	endfunction

	// instruction encoders
	function automatic word_t enc_r(input funct7_t f7, input reg_addr_t rs2, input reg_addr_t rs1,
			input funct3_t f3, input reg_addr_t rd, input opcode_t op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
			input funct3_t f3, input reg_addr_t rd, input opcode_t op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
			input reg_addr_t rs1, input funct3_t f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
			input reg_addr_t rs1, input funct3_t f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd, input opcode_t op);
		return {imm, rd, op};
	endfunction

	function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// RV32I semantics for OP and OP-IMM
	function automatic word_t alu_ref(input funct3_t f3, input logic alt, input word_t a,
			input word_t b);
		word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_ref(input funct3_t f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic emit_li(input reg_addr_t rd, input word_t v);
		word_t up;
		up = v + 32'h800; // rounds for the signed low part
		emit(enc_u(up[31:12], rd, OPC_LUI));
		emit(enc_i(v[11:0], rd, 3'd0, rd, OPC_OP_IMM));
	endtask

	task automatic emit_sw(input reg_addr_t rs2, input int addr);
		emit(enc_s(12'(addr), rs2, 5'd0, 3'b010));
	endtask

	task automatic run_program;
		for (int i = 0; i < 256; i++)
			dmem[i] = fill_word(i);
		wr_addr_q.delete();
		wr_mask_q.delete();
		wr_word_q.delete();
		rd_addr_q.delete();
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check_bit("halted", halted, 1'b0);
		while (!halted)
			@(negedge clk);
	endtask

	task automatic test_alu;
		word_t       a;
		word_t       b;
		word_t       exp_q [$];
		logic [11:0] imm;
		funct3_t     f3;
		logic        alt;
		int          n;
		a = $urandom | 32'h8000_0000; // signs differ for slt against sltu
		b = $urandom & 32'h7fff_ffff;
		prog_len = 0;
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		n = 0;
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 8) ? funct3_t'(k) : ((k == 8) ? 3'd0 : 3'd5);
			alt = (k >= 8);
			emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, OPC_OP));
			emit_sw(5'd3, 'h100 + 4 * n);
			exp_q.push_back(alu_ref(f3, alt, a, b));
			n++;
		end
		for (int k = 0; k < 9; k++) begin
			f3 = (k < 8) ? funct3_t'(k) : 3'd5;
			alt = (k == 8);
			imm = 12'($urandom);
			if (f3 == 3'd1 || f3 == 3'd5)
				imm = {1'b0, alt, 5'd0, imm[4:0]};
			emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
			emit_sw(5'd3, 'h100 + 4 * n);
			exp_q.push_back(alu_ref(f3, alt, a, word_t'($signed(imm))));
			n++;
		end
		emit(EBREAK);
		run_program();
		for (int k = 0; k < 19; k++)
			check_word($sformatf("alu result %0d", k), dmem[8'h40 + k], exp_q[k]);
	endtask

	task automatic test_branch_jump;
		word_t   a;
		word_t   b;
		funct3_t br_f3 [6];
		logic    taken [12];
		int      jal_pc;
		int      jalr_pc;
		a = $urandom;
		b = $urandom;
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		prog_len = 0;
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		emit(enc_i(12'h5a5, 5'd0, 3'd0, 5'd5, OPC_OP_IMM)); // path marker
		for (int k = 0; k < 12; k++) begin
			emit(enc_b(13'd12, (k < 6) ? 5'd2 : 5'd1, 5'd1, br_f3[k % 6]));
			emit_sw(5'd5, 'h200 + 8 * k);
			emit(enc_j(21'd8, 5'd0));
			emit_sw(5'd5, 'h204 + 8 * k);
			taken[k] = branch_ref(br_f3[k % 6], a, (k < 6) ? b : a);
		end
		jal_pc = prog_len * 4;
		emit(enc_j(21'd8, 5'd6));
		emit(EBREAK);
		emit_sw(5'd6, 'h300);
		jalr_pc = prog_len * 4;
		emit(enc_u(20'd0, 5'd7, OPC_AUIPC));
		emit(enc_i(12'd17, 5'd7, 3'd0, 5'd8, OPC_JALR)); // odd offset, bit 0 dropped
		emit(EBREAK);
		emit(EBREAK);
		emit_sw(5'd8, 'h304);
		emit(EBREAK);
		run_program();
		for (int k = 0; k < 12; k++) begin
			check_word($sformatf("branch %0d taken path", k), dmem[8'h81 + 2 * k],
				taken[k] ? 32'h5a5 : fill_word(8'h81 + 2 * k));
			check_word($sformatf("branch %0d fall path", k), dmem[8'h80 + 2 * k],
				taken[k] ? fill_word(8'h80 + 2 * k) : 32'h5a5);
		end
		check_word("jal link", dmem[8'hc0], word_t'(jal_pc + 4));
		check_word("jalr link", dmem[8'hc1], word_t'(jalr_pc + 8));
	endtask

	task automatic test_store_mask;
		word_t  v;
		word_t  word0;
		word_t  word1;
		word_t  e_addr [$];
		wmask_t e_mask [$];
		word_t  e_word [$];
		v = $urandom;
		word0 = fill_word(8'h10);
		word1 = fill_word(8'h14);
		prog_len = 0;
		emit_li(5'd1, v);
		for (int off = 0; off < 4; off++) begin
			emit(enc_s(12'(8'h40 + off), 5'd1, 5'd0, 3'b000));
			word0[8*off +: 8] = v[7:0];
			e_addr.push_back(word_t'(8'h40 + off));
			e_mask.push_back(wmask_t'(4'b0001 << off));
			e_word.push_back(word0);
		end
		for (int off = 0; off < 4; off += 2) begin
			emit(enc_s(12'(8'h50 + off), 5'd1, 5'd0, 3'b001));
			word1[8*off +: 16] = v[15:0];
			e_addr.push_back(word_t'(8'h50 + off));
			e_mask.push_back(wmask_t'(4'b0011 << off));
			e_word.push_back(word1);
		end
		emit(EBREAK);
		run_program();
		if (wr_addr_q.size() != 6) begin
			$display("store mask test saw %0d store pulses instead of 6", wr_addr_q.size());
			errors++;
		end else begin
			for (int i = 0; i < 6; i++) begin
				check_word("dmem_addr", wr_addr_q[i], e_addr[i]);
				check_mask("dmem_wmask", wr_mask_q[i], e_mask[i]);
				check_word("memory word", wr_word_q[i], e_word[i]);
			end
		end
	endtask

	task automatic test_load_round_trip;
		word_t v;
		v = $urandom;
		prog_len = 0;
		emit_li(5'd1, v);
		emit_sw(5'd1, 'h80);
		emit(enc_i(12'h080, 5'd0, 3'b010, 5'd9, OPC_LOAD));
		emit_sw(5'd9, 'h84);
		emit(enc_i(12'h088, 5'd0, 3'b010, 5'd10, OPC_LOAD)); // untouched word
		emit_sw(5'd10, 'h8c);
		emit(EBREAK);
		run_program();
		check_word("reloaded word", dmem[8'h21], v);
		check_word("loaded fill word", dmem[8'h23], fill_word(8'h22));
		if (rd_addr_q.size() != 2) begin
			$display("load test saw %0d read pulses instead of 2", rd_addr_q.size());
			errors++;
		end else begin
			check_word("dmem_addr on load", rd_addr_q[0], 32'h80);
			check_word("dmem_addr on load", rd_addr_q[1], 32'h88);
		end
	endtask

	task automatic test_csr_cycles;
		word_t a;
		word_t b;
		a = $urandom;
		b = $urandom;
		prog_len = 0;
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		emit(enc_i(CSR_MSCRATCH, 5'd1, 3'b001, 5'd3, OPC_SYSTEM)); // csrrw
		emit(enc_i(CSR_MSCRATCH, 5'd2, 3'b010, 5'd4, OPC_SYSTEM)); // csrrs
		emit(enc_i(CSR_MSCRATCH, 5'd0, 3'b010, 5'd5, OPC_SYSTEM));
		emit_sw(5'd3, 'hc0);
		emit_sw(5'd4, 'hc4);
		emit_sw(5'd5, 'hc8);
		emit(enc_i(CSR_MCYCLE, 5'd0, 3'b010, 5'd6, OPC_SYSTEM));
		for (int k = 0; k < 5; k++)
			emit(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
		emit(enc_i(CSR_MCYCLE, 5'd0, 3'b010, 5'd8, OPC_SYSTEM));
		emit_sw(5'd6, 'hcc);
		emit_sw(5'd8, 'hd0);
		emit(EBREAK);
		run_program();
		check_word("mscratch old value", dmem[8'h30], 32'd0);
		check_word("mscratch after csrrw", dmem[8'h31], a);
		check_word("mscratch after csrrs", dmem[8'h32], a | b);
		check_word("mcycle delta", dmem[8'h34] - dmem[8'h33], 32'd12); // 2n plus 2, n is 5
	endtask

	task automatic test_halt;
		prog_len = 0;
		emit(enc_i(12'h055, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
		emit(EBREAK);
		emit_sw(5'd1, 'h10); // must never run
		run_program();
		repeat (20) begin
			@(negedge clk);
			check_bit("halted", halted, 1'b1);
			check_bit("dmem_we", dmem_we, 1'b0);
			check_bit("dmem_re", dmem_re, 1'b0);
		end
		if (wr_addr_q.size() != 0) begin
			$display("a store reached data memory after ebreak");
			errors++;
		end
		check_word("word behind ebreak store", dmem[4], fill_word(4));
	endtask

	initial begin
		rst_n = 1'b0;
		imem_rdata = '0;
		dmem_rdata = '0;
		rd_word = '0;
		errors = 0;
		checks = 0;
		void'($urandom(8));
		test_alu();
		test_branch_jump();
		test_store_mask();
		test_load_round_trip();
		test_csr_cycles();
		test_halt();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_core.f */
design/rv_core_pkg.sv
design/decode_if.sv
design/core_fsm.sv
design/pc_counter.sv
design/decode_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/csr_file.sv
design/rv_core_top.sv
tests/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rv_core \
	-f rv_core.f --Mdir obj_dir -o sim_rv_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output="$(./obj_dir/sim_rv_core)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1
